//--- rtl/smpc_pkg.sv
`default_nettype none

package smpc_pkg;

	typedef struct packed {
		logic       cs_n;
		logic       rw_n;
		logic [5:0] addr;    // Word address A[6:1]
		logic [7:0] wdata;
	} smpc_bus_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
	} smpc_resets_t;

	typedef struct packed {
		logic [7:0] day;
		logic [7:0] hour;
		logic [7:0] min;
		logic [7:0] sec;
	} smpc_time_t;

	typedef struct packed {
		logic       we;
		logic [4:0] addr;
		logic [7:0] data;
	} oreg_wr_t;

	typedef enum logic [4:0] {
		IDLE  = 5'b00001,
		START = 5'b00010,
		WAIT  = 5'b00100,
		EXEC  = 5'b01000,
		END   = 5'b10000
	} cmd_state_e;

	localparam logic [7:0] CMD_MSHON   = 8'h00;
	localparam logic [7:0] CMD_SSHON   = 8'h02;
	localparam logic [7:0] CMD_SSHOFF  = 8'h03;
	localparam logic [7:0] CMD_SNDON   = 8'h06;
	localparam logic [7:0] CMD_SNDOFF  = 8'h07;
	localparam logic [7:0] CMD_CDON    = 8'h08;
	localparam logic [7:0] CMD_CDOFF   = 8'h09;
	localparam logic [7:0] CMD_SYSRES  = 8'h0D;
	localparam logic [7:0] CMD_INTBACK = 8'h10;
	localparam logic [7:0] CMD_SETTIME = 8'h16;
	localparam logic [7:0] CMD_SETSMEM = 8'h17;
	localparam logic [7:0] CMD_NMIREQ  = 8'h18;
	localparam logic [7:0] CMD_RESENAB = 8'h19;
	localparam logic [7:0] CMD_RESDISA = 8'h1A;

	localparam logic [15:0] WAIT_SLAVE   = 16'd120;
	localparam logic [15:0] WAIT_CD      = 16'd159;
	localparam logic [15:0] WAIT_SYSRES  = 16'd400;
	localparam logic [15:0] WAIT_INTBACK = 16'd500;
	localparam logic [15:0] WAIT_SETTIME = 16'd279;
	localparam logic [15:0] WAIT_NMI     = 16'd127;

	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	localparam logic [4:0] OREG_LAST_IDX = 5'd31;
	localparam int         STATUS_BYTES  = 16;
	localparam logic [7:0] INTBACK_KEY   = 8'hF0;
	localparam logic [7:0] YEAR_HI       = 8'h20;
	localparam logic [7:0] YEAR_LO       = 8'h22;
	localparam logic [7:0] MONTH         = 8'h01;

	// Slaves held in reset until their ON command
	localparam smpc_resets_t RESETS_INIT = '{
		mshres_n: 1'b1,
		mshnmi_n: 1'b1,
		sshres_n: 1'b0,
		sshnmi_n: 1'b1,
		sysres_n: 1'b1,
		sndres_n: 1'b0,
		cdres_n:  1'b1
	};

endpackage

`default_nettype wire

//--- rtl/smpc_oreg_ram.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_oreg_ram (
	input  logic                CLK,
	input  smpc_pkg::oreg_wr_t  oreg_wr,
	input  logic [4:0]          raddr,
	output logic [7:0]          rdata
);

	logic [7:0] mem [32];    // OREG0 to OREG31

	always_ff @(posedge CLK) begin
		if (oreg_wr.we) mem[oreg_wr.addr] <= oreg_wr.data;
	end

	assign rdata = mem[raddr];    // Async read for the host mux

endmodule

`default_nettype wire

//--- rtl/smpc_rtc.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	output smpc_pkg::smpc_time_t  now
);

	import smpc_pkg::*;

	localparam int CNT_W = $clog2(TICKS_PER_SEC + 1);

	logic [CNT_W-1:0] pre_cnt;
	logic             sec_tick;

	// BCD increment with wrap to 00 after last
	function automatic logic [7:0] bcd_next(input logic [7:0] v, input logic [7:0] last);
		logic [7:0] r;
		if (v == last) r = 8'h00;
		else if (v[3:0] == 4'd9) r = {v[7:4] + 4'd1, 4'h0};
		else r = v + 8'd1;
		return r;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pre_cnt  <= '0;
			sec_tick <= 1'b0;
		end else begin
			sec_tick <= 1'b0;
			if (pre_cnt == CNT_W'(TICKS_PER_SEC - 1)) begin
				pre_cnt  <= '0;
				sec_tick <= 1'b1;
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			now <= '0;
		end else if (sec_tick) begin
			now.sec <= bcd_next(now.sec, 8'h59);
			if (now.sec == 8'h59) begin
				now.min <= bcd_next(now.min, 8'h59);
				if (now.min == 8'h59) begin
					now.hour <= bcd_next(now.hour, 8'h23);
					if (now.hour == 8'h23) now.day <= bcd_next(now.day, 8'h99);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/smpc_host_regs.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_host_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  smpc_pkg::smpc_bus_t  bus,
	input  logic                 sf_clear,
	input  logic [2:0]           sr_hi,
	input  logic [7:0]           oreg_rdata,
	output logic [7:0]           rdata,
	output logic [7:0]           comreg,
	output logic [31:0]          ireg,
	output logic                 cmd_req,
	output logic [4:0]           oreg_raddr
);

	import smpc_pkg::*;

	localparam int IREG_COUNT = 7;

	logic                 cs_n_q;
	logic                 rw_n_q;
	logic                 wr_stb;
	logic                 rd_stb;
	logic [6:0]           byte_addr;
	logic [2:0]           ireg_idx;
	logic                 ireg_hit;
	logic [IREG_COUNT-1:0][7:0] ireg_q;
	logic                 sf;
	logic [7:0]           sr;
	logic [7:0]           rd_mux;

	assign byte_addr = {bus.addr, 1'b1};
	assign wr_stb    = !bus.rw_n && rw_n_q && !bus.cs_n;
	assign rd_stb    = !bus.cs_n && cs_n_q && bus.rw_n;

	assign ireg_idx   = 3'(bus.addr - ADDR_IREG0[6:1]);
	assign ireg_hit   = byte_addr >= ADDR_IREG0
		&& byte_addr <= ADDR_IREG0 + 7'(2 * (IREG_COUNT - 1));
	assign oreg_raddr = 5'(bus.addr - ADDR_OREG_FIRST[6:1]);

	assign ireg = ireg_q[3:0];    // IREG0 in the low byte
	assign sr   = {sr_hi, 1'b0, ireg_q[1][7:4]};

	always_comb begin
		if (byte_addr >= ADDR_OREG_FIRST && byte_addr <= ADDR_OREG_LAST) begin
			rd_mux = oreg_rdata;
		end else if (byte_addr == ADDR_SR) begin
			rd_mux = sr;
		end else if (byte_addr == ADDR_SF) begin
			rd_mux = {7'b0000000, sf};
		end else begin
			rd_mux = 8'h00;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_q  <= 1'b1;
			rw_n_q  <= 1'b1;
			comreg  <= 8'h00;
			ireg_q  <= '0;
			sf      <= 1'b0;
			cmd_req <= 1'b0;
			rdata   <= 8'h00;
		end else begin
			cs_n_q  <= bus.cs_n;
			rw_n_q  <= bus.rw_n;
			cmd_req <= 1'b0;

			if (sf_clear) sf <= 1'b0;    // Command done

			if (wr_stb) begin
				if (ireg_hit) begin
					ireg_q[ireg_idx] <= bus.wdata;
				end else if (byte_addr == ADDR_COMREG) begin
					comreg  <= bus.wdata;
					cmd_req <= 1'b1;
				end else if (byte_addr == ADDR_SF && bus.wdata[0]) begin
					sf <= 1'b1;    // Host set wins over a same-cycle clear
				end
			end

			if (rd_stb) rdata <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- rtl/smpc_cmd_seq.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_cmd_seq (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic [7:0]              comreg,
	input  logic [31:0]             ireg,
	input  logic                    cmd_req,
	input  logic [3:0]              area_code,
	input  smpc_pkg::smpc_time_t    now,
	output smpc_pkg::smpc_resets_t  resets,
	output logic                    mirq_n,
	output logic                    sf_clear,
	output logic [2:0]              sr_hi,
	output smpc_pkg::oreg_wr_t      oreg_wr
);

	import smpc_pkg::*;

	cmd_state_e      state;
	logic            pending;
	logic [15:0]     wait_cnt;
	logic [4:0]      oreg_cnt;
	logic            resd;
	logic            ste;
	logic [3:0][7:0] smem;
	logic [15:0]     wait_len;
	logic            known;
	logic            is_intback;
	logic            intback_ok;
	logic [7:0]      status_byte;

	assign is_intback = comreg == CMD_INTBACK;
	// Key in IREG2, status request in IREG0 bit 0
	assign intback_ok = ireg[23:16] == INTBACK_KEY && ireg[0];

	always_comb begin
		wait_len = WAIT_SLAVE;
		known    = 1'b1;
		case (comreg)
			CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF: wait_len = WAIT_SLAVE;
			CMD_CDON, CMD_CDOFF, CMD_SETSMEM:                        wait_len = WAIT_CD;
			CMD_SYSRES:                                              wait_len = WAIT_SYSRES;
			CMD_INTBACK:                                             wait_len = WAIT_INTBACK;
			CMD_SETTIME:                                             wait_len = WAIT_SETTIME;
			CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA:                    wait_len = WAIT_NMI;
			default:                                                 known    = 1'b0;
		endcase
	end

	always_comb begin
		if (oreg_cnt == OREG_LAST_IDX) begin
			status_byte = comreg;
		end else if (oreg_cnt >= STATUS_BYTES) begin
			status_byte = 8'h00;
		end else begin
			case (oreg_cnt[3:0])
				4'd0:  status_byte = {ste, resd, 6'b000000};
				4'd1:  status_byte = YEAR_HI;
				4'd2:  status_byte = YEAR_LO;
				4'd3:  status_byte = MONTH;
				4'd4:  status_byte = now.day;
				4'd5:  status_byte = now.hour;
				4'd6:  status_byte = now.min;
				4'd7:  status_byte = now.sec;
				4'd9:  status_byte = {4'b0000, area_code};
				4'd10: status_byte = {4'b0011, ~resets.mshnmi_n, 1'b1,
					~resets.sysres_n, ~resets.sndres_n};
				4'd11: status_byte = {1'b0, ~resets.cdres_n, 6'b000000};
				4'd12, 4'd13, 4'd14, 4'd15: status_byte = smem[oreg_cnt[1:0]];
				default: status_byte = 8'h00;
			endcase
		end
	end

	always_comb begin
		sf_clear     = 1'b0;
		oreg_wr.we   = 1'b0;
		oreg_wr.addr = OREG_LAST_IDX;
		oreg_wr.data = comreg;
		if (state == EXEC) begin
			oreg_wr.we = 1'b1;
			if (is_intback) begin
				oreg_wr.addr = oreg_cnt;
				oreg_wr.data = status_byte;
				sf_clear     = oreg_cnt == 5'd0;    // SF drops on the first status byte
			end else begin
				sf_clear = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (state == EXEC && comreg == CMD_SETSMEM) smem <= ireg;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state    <= IDLE;
			pending  <= 1'b0;
			wait_cnt <= 16'd0;
			oreg_cnt <= 5'd0;
			resets   <= RESETS_INIT;
			mirq_n   <= 1'b1;
			sr_hi    <= 3'b000;
			resd     <= 1'b1;
			ste      <= 1'b0;
		end else begin
			// Writes during a busy command fold into one request
			pending <= (pending || cmd_req) && state != IDLE;

			unique case (state)
				IDLE: begin
					if (pending || cmd_req) state <= START;
					oreg_cnt <= 5'd0;
				end

				START: begin
					if (is_intback && !intback_ok) begin
						state <= END;
					end else begin
						mirq_n <= 1'b1;    // Next accepted command releases the interrupt
						sr_hi  <= 3'b000;
						if (known) begin
							wait_cnt <= wait_len - 16'd1;
							state    <= WAIT;
						end else begin
							state <= EXEC;
						end
					end
				end

				WAIT: begin
					if (wait_cnt == 16'd0) state <= EXEC;
					else wait_cnt <= wait_cnt - 16'd1;
				end

				EXEC: begin
					state <= END;
					case (comreg)
						CMD_MSHON:   resets.mshres_n <= 1'b1;
						CMD_SSHON:   resets.sshres_n <= 1'b1;
						CMD_SSHOFF:  resets.sshres_n <= 1'b0;
						CMD_SNDON:   resets.sndres_n <= 1'b1;
						CMD_SNDOFF:  resets.sndres_n <= 1'b0;
						CMD_CDON:    resets.cdres_n  <= 1'b1;
						CMD_CDOFF:   resets.cdres_n  <= 1'b0;
						CMD_SYSRES:  resets          <= '0;
						CMD_NMIREQ:  resets.mshnmi_n <= 1'b0;
						CMD_RESENAB: resd            <= 1'b0;
						CMD_RESDISA: resd            <= 1'b1;
						CMD_SETTIME: ste             <= 1'b1;
						CMD_INTBACK: begin
							oreg_cnt <= oreg_cnt + 5'd1;
							if (oreg_cnt == OREG_LAST_IDX) begin
								sr_hi  <= 3'b010;
								mirq_n <= 1'b0;
							end else begin
								state <= EXEC;    // One OREG byte per cycle
							end
						end
						default: ;
					endcase
				end

				END: begin
					if (comreg == CMD_SYSRES) resets <= '1;
					if (comreg == CMD_NMIREQ) resets.mshnmi_n <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/smpc_top.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_top #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  smpc_pkg::smpc_bus_t     bus,
	input  logic [3:0]              area_code,
	output logic [7:0]              rdata,
	output smpc_pkg::smpc_resets_t  resets,
	output logic                    mirq_n
);

	import smpc_pkg::*;

	logic [7:0]  comreg;
	logic [31:0] ireg;
	logic        cmd_req;
	logic        sf_clear;
	logic [2:0]  sr_hi;
	logic [4:0]  oreg_raddr;
	logic [7:0]  oreg_rdata;
	oreg_wr_t    oreg_wr;
	smpc_time_t  now;

	smpc_host_regs u_host_regs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.bus        (bus),
		.sf_clear   (sf_clear),
		.sr_hi      (sr_hi),
		.oreg_rdata (oreg_rdata),
		.rdata      (rdata),
		.comreg     (comreg),
		.ireg       (ireg),
		.cmd_req    (cmd_req),
		.oreg_raddr (oreg_raddr)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.comreg    (comreg),
		.ireg      (ireg),
		.cmd_req   (cmd_req),
		.area_code (area_code),
		.now       (now),
		.resets    (resets),
		.mirq_n    (mirq_n),
		.sf_clear  (sf_clear),
		.sr_hi     (sr_hi),
		.oreg_wr   (oreg_wr)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK   (CLK),
		.RST_N (RST_N),
		.now   (now)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK     (CLK),
		.oreg_wr (oreg_wr),
		.raddr   (oreg_raddr),
		.rdata   (oreg_rdata)
	);

endmodule

`default_nettype wire

//--- bench/smpc_properties.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_properties (
	input logic                    CLK,
	input logic                    RST_N,
	input smpc_pkg::cmd_state_e    state,
	input logic                    sf_clear,
	input logic [7:0]              comreg,
	input smpc_pkg::oreg_wr_t      oreg_wr,
	input smpc_pkg::smpc_resets_t  resets,
	input logic                    mirq_n
);

	import smpc_pkg::*;

	int fail_count = 0;    // Read by the testbench at the end

	a_sf_clear_in_exec: assert property (@(posedge CLK) disable iff (!RST_N)
		sf_clear |-> state == EXEC)
		else begin
			$error("sf_clear pulsed outside EXEC");
			fail_count++;
		end

	a_oreg31_is_comreg: assert property (@(posedge CLK) disable iff (!RST_N)
		(oreg_wr.we && oreg_wr.addr == OREG_LAST_IDX) |-> oreg_wr.data == comreg)
		else begin
			$error("OREG31 write does not carry COMREG");
			fail_count++;
		end

	a_sysres_enter: assert property (@(posedge CLK) disable iff (!RST_N)
		(state == EXEC && comreg == CMD_SYSRES) |=> resets == '0)
		else begin
			$error("SYSRES did not pull all lines low");
			fail_count++;
		end

	a_sysres_one_cycle: assert property (@(posedge CLK) disable iff (!RST_N)
		resets == '0 |=> resets != '0)
		else begin
			$error("All-low line state held longer than one cycle");
			fail_count++;
		end

	a_mirq_fall_in_exec: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(mirq_n) |-> $past(state) == EXEC)
		else begin
			$error("mirq_n fell outside EXEC");
			fail_count++;
		end

endmodule

bind smpc_cmd_seq smpc_properties u_props (
	.CLK      (CLK),
	.RST_N    (RST_N),
	.state    (state),
	.sf_clear (sf_clear),
	.comreg   (comreg),
	.oreg_wr  (oreg_wr),
	.resets   (resets),
	.mirq_n   (mirq_n)
);

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;    // Release away from the sampling edge
	end

endmodule

`default_nettype wire

//--- bench/smpc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module smpc_tb;

	import smpc_pkg::*;

	localparam int     TICKS       = 64;
	localparam int     CLK_NS      = 8;
	localparam int     LINE_CMDS   = 60;
	localparam int     NUM_CMDS    = LINE_CMDS + 17;
	localparam int     POLL_LIMIT  = int'(WAIT_INTBACK);
	localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * (int'(WAIT_INTBACK) + 64) * CLK_NS * 4;

	logic         CLK;
	logic         RST_N;
	smpc_bus_t    bus;
	logic [3:0]   area_code;
	logic [7:0]   rdata;
	smpc_resets_t resets;
	logic         mirq_n;

	smpc_resets_t model_resets;
	logic         model_resd;
	logic         model_ste;
	logic [7:0]   model_ireg [7];
	logic [7:0]   model_smem [4];
	logic [7:0]   model_oreg [32];
	int           cycles = 0;
	int           last_done_cycle;
	int           err_count = 0;

	tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) u_clock (.CLK(CLK), .RST_N(RST_N));

	smpc_top #(.TICKS_PER_SEC(TICKS)) u_dut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.bus       (bus),
		.area_code (area_code),
		.rdata     (rdata),
		.resets    (resets),
		.mirq_n    (mirq_n)
	);

	always @(posedge CLK) if (RST_N) cycles <= cycles + 1;    // Time since reset release

	task automatic stop_on_error();
		err_count++;
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_resets(input string name, input smpc_resets_t got, input smpc_resets_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	function automatic int bcd_val(input logic [7:0] b);
		return int'(b[7:4]) * 10 + int'(b[3:0]);
	endfunction

	function automatic int time_to_secs(input smpc_time_t t);
		return ((bcd_val(t.day) * 24 + bcd_val(t.hour)) * 60 + bcd_val(t.min)) * 60
			+ bcd_val(t.sec);
	endfunction

	function automatic bit bcd_ok(input smpc_time_t t);
		return t.day[7:4] <= 4'd9 && t.day[3:0] <= 4'd9 && t.hour <= 8'h23
			&& t.hour[3:0] <= 4'd9 && t.min <= 8'h59 && t.min[3:0] <= 4'd9
			&& t.sec <= 8'h59 && t.sec[3:0] <= 4'd9;
	endfunction

	task automatic check_time(input string name, input smpc_time_t got, input int lo, input int hi);
		int secs;
		secs = time_to_secs(got);
		if (!bcd_ok(got) || secs < lo || secs > hi) begin
			$display("FAILED %s: got %h, expected BCD time of %h to %h seconds", name, got, lo, hi);
			stop_on_error();
		end
	endtask

	function automatic bit is_known(input logic [7:0] code);
		case (code)
			CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF, CMD_CDON, CMD_CDOFF,
			CMD_SYSRES, CMD_INTBACK, CMD_SETTIME, CMD_SETSMEM, CMD_NMIREQ, CMD_RESENAB,
			CMD_RESDISA: return 1'b1;
			default:     return 1'b0;
		endcase
	endfunction

	function automatic logic [6:0] oreg_addr(input int idx);
		return ADDR_OREG_FIRST + 7'(2 * idx);
	endfunction

	task automatic write_reg(input logic [6:0] byte_addr, input logic [7:0] data);
		@(negedge CLK);
		bus.addr  = byte_addr[6:1];
		bus.wdata = data;
		bus.cs_n  = 1'b0;
		bus.rw_n  = 1'b0;
		@(negedge CLK);
		bus.cs_n = 1'b1;
		bus.rw_n = 1'b1;
	endtask

	task automatic read_reg(input logic [6:0] byte_addr, output logic [7:0] data);
		@(negedge CLK);
		bus.addr = byte_addr[6:1];
		bus.rw_n = 1'b1;
		bus.cs_n = 1'b0;
		@(negedge CLK);
		data     = rdata;    // Captured at the edge just passed
		bus.cs_n = 1'b1;
	endtask

	task automatic set_ireg(input int idx, input logic [7:0] val);
		model_ireg[idx] = val;
		write_reg(ADDR_IREG0 + 7'(2 * idx), val);
	endtask

	task automatic wait_mirq_low();
		int n;
		n = 0;
		while (mirq_n) begin
			if (n == 64) begin
				$display("mirq_n did not fall after a valid INTBACK");
				stop_on_error();
			end
			@(negedge CLK);
			n++;
		end
	endtask

	task automatic run_cmd(input logic [7:0] code);
		logic [7:0] sf;
		logic [7:0] got;
		int         polls;
		write_reg(ADDR_COMREG, code);
		write_reg(ADDR_SF, 8'h01);
		polls = 0;
		do begin
			if (polls == POLL_LIMIT) begin
				$display("SF still set after %0d polls for command %h", polls, code);
				stop_on_error();
			end
			read_reg(ADDR_SF, sf);
			polls++;
		end while (sf[0]);
		last_done_cycle = cycles;
		if (code == CMD_INTBACK) wait_mirq_low();    // Status bytes still being written
		repeat (2) @(negedge CLK);
		case (code)
			CMD_MSHON:   model_resets.mshres_n = 1'b1;
			CMD_SSHON:   model_resets.sshres_n = 1'b1;
			CMD_SSHOFF:  model_resets.sshres_n = 1'b0;
			CMD_SNDON:   model_resets.sndres_n = 1'b1;
			CMD_SNDOFF:  model_resets.sndres_n = 1'b0;
			CMD_CDON:    model_resets.cdres_n  = 1'b1;
			CMD_CDOFF:   model_resets.cdres_n  = 1'b0;
			CMD_SYSRES:  model_resets          = '1;
			CMD_RESENAB: model_resd            = 1'b0;
			CMD_RESDISA: model_resd            = 1'b1;
			CMD_SETTIME: model_ste             = 1'b1;
			CMD_SETSMEM: begin
				for (int i = 0; i < 4; i++) model_smem[i] = model_ireg[i];
			end
			default: ;
		endcase
		model_oreg[31] = code;
		check_resets("resets", resets, model_resets);
		read_reg(oreg_addr(31), got);
		check_byte("OREG31", got, code);
	endtask

	task automatic run_intback(output smpc_time_t t);
		logic [7:0] got;
		set_ireg(0, 8'($urandom) | 8'h01);
		set_ireg(1, 8'($urandom));
		set_ireg(2, INTBACK_KEY);
		run_cmd(CMD_INTBACK);
		model_oreg[0]  = {model_ste, model_resd, 6'b000000};
		model_oreg[1]  = YEAR_HI;
		model_oreg[2]  = YEAR_LO;
		model_oreg[3]  = MONTH;
		model_oreg[8]  = 8'h00;
		model_oreg[9]  = {4'b0000, area_code};
		model_oreg[10] = {4'b0011, ~model_resets.mshnmi_n, 1'b1, ~model_resets.sysres_n,
			~model_resets.sndres_n};
		model_oreg[11] = {1'b0, ~model_resets.cdres_n, 6'b000000};
		for (int i = 0; i < 4; i++) model_oreg[12 + i] = model_smem[i];
		for (int i = 16; i < 31; i++) model_oreg[i] = 8'h00;
		for (int i = 0; i < 32; i++) begin
			read_reg(oreg_addr(i), got);
			if (i >= 4 && i <= 7) model_oreg[i] = got;    // Time, checked by the caller
			else check_byte($sformatf("OREG%0d", i), got, model_oreg[i]);
		end
		t = {model_oreg[4], model_oreg[5], model_oreg[6], model_oreg[7]};
		read_reg(ADDR_SR, got);
		check_byte("SR", got, {3'b010, 1'b0, model_ireg[1][7:4]});
		check_bit("mirq_n", mirq_n, 1'b0);
	endtask

	task automatic test_reset();
		logic [7:0] got;
		check_resets("resets", resets, RESETS_INIT);
		check_bit("mirq_n", mirq_n, 1'b1);
		read_reg(ADDR_SR, got);
		check_byte("SR", got, 8'h00);
		read_reg(ADDR_SF, got);
		check_byte("SF", got, 8'h00);
	endtask

	task automatic test_line_cmds();
		logic [7:0] code;
		for (int n = 0; n < LINE_CMDS; n++) begin
			case ($urandom_range(0, 9))
				0: code = CMD_MSHON;
				1: code = CMD_SSHON;
				2: code = CMD_SSHOFF;
				3: code = CMD_SNDON;
				4: code = CMD_SNDOFF;
				5: code = CMD_CDON;
				6: code = CMD_CDOFF;
				7: code = CMD_SYSRES;
				8: code = CMD_NMIREQ;
				default: begin
					do code = 8'($urandom); while (is_known(code));
				end
			endcase
			run_cmd(code);
		end
	endtask

	task automatic test_smem_intback();
		smpc_time_t t;
		for (int i = 0; i < 4; i++) set_ireg(i, 8'($urandom));
		run_cmd(CMD_SETSMEM);
		run_intback(t);
	endtask

	task automatic test_bad_intback();
		logic [7:0] key;
		logic [7:0] got;
		for (int n = 0; n < 4; n++) begin
			if (n[0]) begin
				do key = 8'($urandom); while (key == INTBACK_KEY);
				set_ireg(2, key);
				set_ireg(0, 8'($urandom));
			end else begin
				set_ireg(2, INTBACK_KEY);
				set_ireg(0, 8'($urandom) & 8'hFE);    // No status request
			end
			set_ireg(1, 8'($urandom));
			write_reg(ADDR_COMREG, CMD_INTBACK);
			write_reg(ADDR_SF, 8'h01);
			repeat (8) @(negedge CLK);    // START, END and back to IDLE
			read_reg(ADDR_SF, got);
			check_byte("SF", got, 8'h01);
			read_reg(ADDR_SR, got);
			check_byte("SR", got, {3'b010, 1'b0, model_ireg[1][7:4]});
			check_bit("mirq_n", mirq_n, 1'b0);
			for (int i = 0; i < 32; i++) begin
				read_reg(oreg_addr(i), got);
				check_byte($sformatf("OREG%0d", i), got, model_oreg[i]);
			end
		end
	endtask

	task automatic test_resd_ste();
		smpc_time_t t;
		for (int n = 0; n < 8; n++) begin
			case ($urandom_range(0, 2))
				0:       run_cmd(CMD_RESENAB);
				1:       run_cmd(CMD_RESDISA);
				default: run_cmd(CMD_SETTIME);
			endcase
		end
		run_intback(t);    // Byte 0 carries STE and RESD
	endtask

	task automatic test_rtc();
		smpc_time_t t1;
		smpc_time_t t2;
		int         c1;
		int         span;
		run_intback(t1);
		c1 = last_done_cycle;
		check_time("now", t1, c1 / TICKS - 1, c1 / TICKS + 1);
		repeat (3000 + $urandom_range(0, 3000)) @(negedge CLK);
		run_intback(t2);
		span = (last_done_cycle - c1) / TICKS;
		check_time("now", t2, time_to_secs(t1) + span - 1, time_to_secs(t1) + span + 1);
	endtask

	initial begin
		void'($urandom(32'hbf3));
		bus       = '{cs_n: 1'b1, rw_n: 1'b1, addr: 6'h00, wdata: 8'h00};
		area_code = 4'($urandom);
		model_resets = RESETS_INIT;
		model_resd   = 1'b1;
		model_ste    = 1'b0;
		for (int i = 0; i < 7; i++) model_ireg[i] = 8'h00;
		for (int i = 0; i < 4; i++) model_smem[i] = 8'h00;
		wait (RST_N === 1'b1);
		@(negedge CLK);
		test_reset();
		test_line_cmds();
		test_smem_intback();
		test_bad_intback();
		test_resd_ste();
		test_rtc();
		if (err_count == 0 && u_dut.u_cmd_seq.u_props.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("Assertions in the command sequencer failed during the run");
			stop_on_error();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		stop_on_error();
	end

endmodule

`default_nettype wire

//--- smpc_top.f
rtl/smpc_pkg.sv
rtl/smpc_oreg_ram.sv
rtl/smpc_rtc.sv
rtl/smpc_host_regs.sv
rtl/smpc_cmd_seq.sv
rtl/smpc_top.sv
bench/smpc_properties.sv
bench/tb_clock.sv
bench/smpc_tb.sv
